// ==== common/ninjin_pkg.sv ====
package ninjin_pkg;

  // ========================================================================
  // Widths
  // ========================================================================

  localparam int DWIDTH      = 16;
  localparam int BWIDTH      = 32;
  localparam int ACCWIDTH    = 40;
  localparam int IMGSIZE     = 12;
  localparam int NETSIZE     = 12;
  localparam int LWIDTH      = 10;
  localparam int FRAC_BITS   = 8;

  // Host address: region in the top 2 bits, register index in the low bits
  localparam int HOST_AWIDTH = 16;
  localparam int REGION_LSB  = HOST_AWIDTH - 2;
  localparam int REGLOG      = 4;

  // ========================================================================
  // Register fields
  // ========================================================================

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int FLAG_BIAS_BIT   = 0;
  localparam int FLAG_RELU_BIT   = 1;
  localparam int CTRL_START_BIT  = 0;

  // ========================================================================
  // Types
  // ========================================================================

  typedef logic signed [DWIDTH-1:0]   data_t;
  typedef logic        [BWIDTH-1:0]   word_t;
  typedef logic signed [ACCWIDTH-1:0] acc_t;
  typedef logic [IMGSIZE-1:0]         img_addr_t;
  typedef logic [NETSIZE-1:0]         net_addr_t;
  typedef logic [LWIDTH-1:0]          len_t;
  typedef logic [HOST_AWIDTH-1:0]     host_addr_t;

  // Saturation limits of data_t
  localparam data_t DATA_MAX = {1'b0, {(DWIDTH-1){1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  typedef enum logic [1:0] {
    REGION_REG = 2'd0,
    REGION_IMG = 2'd1,
    REGION_NET = 2'd2
  } region_t;

  typedef enum logic [REGLOG-1:0] {
    REG_CTRL       = 4'd0,
    REG_STATUS     = 4'd1,
    REG_IN_OFFSET  = 4'd2,
    REG_OUT_OFFSET = 4'd3,
    REG_NET_OFFSET = 4'd4,
    REG_TOTAL_IN   = 4'd5,
    REG_TOTAL_OUT  = 4'd6,
    REG_FLAGS      = 4'd7
  } reg_idx_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_BIAS,
    S_MAC,
    S_DRAIN,
    S_WRITE,
    S_DONE
  } gobou_state_t;

endpackage

// ==== gobou/gobou_core.sv ====
module gobou_core
  import ninjin_pkg::*;
  ( input  logic      clk
  , input  logic      xrst
  // Host write port
  , input  logic      net_we
  , input  net_addr_t net_waddr
  , input  data_t     net_wdata
  // Issue from ctrl
  , input  net_addr_t w_addr
  , input  logic      mac_valid
  , input  logic      mac_first
  , input  logic      mac_last
  , input  data_t     img_rdata
  , input  logic      bias_en
  , input  logic      relu_en
  , output logic      res_valid
  , output data_t     res_data
  );

  data_t net_mem [0:2**NETSIZE-1];
  data_t w_rdata;
  logic  v1;
  logic  f1;
  logic  l1;
  acc_t  acc_q;
  acc_t  prod;
  acc_t  acc_sum;
  acc_t  shifted;
  acc_t  biased;
  acc_t  activated;
  data_t bias_q;
  data_t bias_cur;
  data_t sat;

  always_ff @(posedge clk) begin
    if (net_we)
      net_mem[net_waddr] <= net_wdata;
    w_rdata <= net_mem[w_addr];
  end

  // Issue flags, one cycle late to meet the memory data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      v1        <= 1'b0;
      f1        <= 1'b0;
      l1        <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      v1        <= mac_valid;
      f1        <= mac_valid && mac_first;
      l1        <= mac_valid && mac_last;
      res_valid <= l1;
    end
  end

  // ========================================================================
  // Datapath
  // ========================================================================

  always_comb begin
    prod     = w_rdata * img_rdata;
    // First issue carries the bias word, not a product
    acc_sum  = f1 ? '0 : acc_q + prod;
    bias_cur = f1 ? w_rdata : bias_q;
    shifted  = acc_sum >>> FRAC_BITS;
    biased   = bias_en ? shifted + acc_t'(bias_cur) : shifted;
    activated = (relu_en && biased[ACCWIDTH-1]) ? '0 : biased;
    if (activated > acc_t'(DATA_MAX))
      sat = DATA_MAX;
    else if (activated < acc_t'(DATA_MIN))
      sat = DATA_MIN;
    else
      sat = activated[DWIDTH-1:0];
  end

  always_ff @(posedge clk) begin
    if (v1)
      acc_q <= acc_sum;
    if (f1)
      bias_q <= w_rdata;
    if (l1)
      res_data <= sat;
  end

endmodule

// ==== gobou/gobou_ctrl.sv ====
module gobou_ctrl
  import ninjin_pkg::*;
  ( input  logic      clk
  , input  logic      xrst
  , input  logic      start
  , input  img_addr_t in_offset
  , input  img_addr_t out_offset
  , input  net_addr_t net_offset
  , input  len_t      total_in
  , input  len_t      total_out
  , input  logic      res_valid
  , input  data_t     res_data
  , output logic      busy
  , output logic      done
  // Image buffer
  , output logic      eng_we
  , output img_addr_t eng_addr
  , output data_t     eng_wdata
  // Core issue
  , output logic      mac_valid
  , output logic      mac_first
  , output logic      mac_last
  , output net_addr_t w_addr
  );

  gobou_state_t state;
  len_t         out_cnt;
  len_t         in_cnt;
  net_addr_t    row;
  img_addr_t    out_addr;
  logic         in_last;
  logic         out_last;

  assign in_last  = in_cnt == total_in - 1'b1;
  assign out_last = out_cnt == total_out - 1'b1;

  // ========================================================================
  // FSM
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= S_IDLE;
      out_cnt  <= '0;
      in_cnt   <= '0;
      row      <= '0;
      out_addr <= '0;
    end else begin
      case (state)
        S_IDLE:
          if (start) begin
            out_cnt  <= '0;
            row      <= net_offset;
            out_addr <= out_offset;
            state    <= (total_out == '0) ? S_DONE : S_BIAS;
          end
        S_BIAS: begin
          in_cnt <= '0;
          state  <= (total_in == '0) ? S_DRAIN : S_MAC;
        end
        S_MAC: begin
          in_cnt <= in_cnt + 1'b1;
          if (in_last)
            state <= S_DRAIN;
        end
        S_DRAIN:
          if (res_valid)
            state <= S_WRITE;
        S_WRITE: begin
          out_cnt  <= out_cnt + 1'b1;
          // Next row skips the bias word and total_in weights
          row      <= row + net_addr_t'(total_in) + 1'b1;
          out_addr <= out_addr + 1'b1;
          state    <= out_last ? S_DONE : S_BIAS;
        end
        S_DONE:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ========================================================================
  // Outputs
  // ========================================================================

  assign busy = state != S_IDLE;
  assign done = state == S_DONE;

  assign mac_valid = state == S_BIAS || state == S_MAC;
  assign mac_first = state == S_BIAS;
  assign mac_last  = (state == S_BIAS && total_in == '0) || (state == S_MAC && in_last);

  // Bias sits at the row start, weight i right after it
  assign w_addr = mac_first ? row : row + net_addr_t'(in_cnt) + 1'b1;

  assign eng_we    = state == S_WRITE;
  assign eng_addr  = eng_we ? out_addr : in_offset + img_addr_t'(in_cnt);
  assign eng_wdata = res_data;

endmodule

// ==== rtl/ninjin_host.sv ====
module ninjin_host
  import ninjin_pkg::*;
  ( input  logic       clk
  , input  logic       xrst
  // Host command and response
  , input  logic       cmd_valid
  , input  logic       cmd_we
  , input  host_addr_t cmd_addr
  , input  word_t      cmd_wdata
  , output logic       cmd_ready
  , output logic       rsp_valid
  , output word_t      rsp_rdata
  , input  logic       rsp_ready
  // Image buffer
  , input  logic       img_ready
  , input  data_t      img_rdata
  , output logic       host_img_we
  , output img_addr_t  host_img_addr
  , output data_t      host_img_wdata
  // Weight memory
  , output logic       net_we
  , output net_addr_t  net_waddr
  , output data_t      net_wdata
  // Engine
  , input  logic       busy
  , input  logic       done
  , output logic       start
  , output img_addr_t  in_offset
  , output img_addr_t  out_offset
  , output net_addr_t  net_offset
  , output len_t       total_in
  , output len_t       total_out
  , output logic       bias_en
  , output logic       relu_en
  );

  region_t  cmd_region;
  reg_idx_t cmd_idx;
  logic     reg_hit;
  logic     accept;
  logic     rsp_hold;
  logic     start_cmd;
  logic     idle;
  logic     img_rd_q;
  logic     done_flag;
  word_t    reg_rdata;
  word_t    img_word;
  word_t    rsp_data_q;

  // ========================================================================
  // Decode
  // ========================================================================

  assign cmd_region = region_t'(cmd_addr[HOST_AWIDTH-1:REGION_LSB]);
  assign cmd_idx    = reg_idx_t'(cmd_addr[REGLOG-1:0]);
  assign reg_hit    = cmd_region == REGION_REG && cmd_addr[REGION_LSB-1:REGLOG] == '0;

  // Image accesses wait while the engine owns the buffer
  assign cmd_ready = idle && !(cmd_region == REGION_IMG && !img_ready);
  assign accept    = cmd_valid && cmd_ready;
  assign rsp_hold  = rsp_valid && !rsp_ready;

  assign host_img_we    = accept && cmd_we && cmd_region == REGION_IMG;
  assign host_img_addr  = cmd_addr[IMGSIZE-1:0];
  assign host_img_wdata = cmd_wdata[DWIDTH-1:0];

  assign net_we    = accept && cmd_we && cmd_region == REGION_NET;
  assign net_waddr = cmd_addr[NETSIZE-1:0];
  assign net_wdata = cmd_wdata[DWIDTH-1:0];

  assign start_cmd = accept && cmd_we && reg_hit && cmd_idx == REG_CTRL
                  && cmd_wdata[CTRL_START_BIT] && !busy;

  // ========================================================================
  // Response
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      idle      <= 1'b0;
      rsp_valid <= 1'b0;
      img_rd_q  <= 1'b0;
    end else begin
      idle      <= !accept && !rsp_hold;
      rsp_valid <= accept || rsp_hold;
      img_rd_q  <= accept && !cmd_we && cmd_region == REGION_IMG;
    end
  end

  assign img_word = {{(BWIDTH-DWIDTH){img_rdata[DWIDTH-1]}}, img_rdata};

  // Image data is live for one cycle, then held here
  always_ff @(posedge clk) begin
    if (accept)
      rsp_data_q <= (!cmd_we && reg_hit) ? reg_rdata : '0;
    else if (img_rd_q)
      rsp_data_q <= img_word;
  end

  assign rsp_rdata = img_rd_q ? img_word : rsp_data_q;

  always_comb begin
    reg_rdata = '0;
    case (cmd_idx)
      REG_STATUS: begin
        reg_rdata[STATUS_BUSY_BIT] = busy;
        reg_rdata[STATUS_DONE_BIT] = done_flag;
      end
      REG_IN_OFFSET:  reg_rdata = word_t'(in_offset);
      REG_OUT_OFFSET: reg_rdata = word_t'(out_offset);
      REG_NET_OFFSET: reg_rdata = word_t'(net_offset);
      REG_TOTAL_IN:   reg_rdata = word_t'(total_in);
      REG_TOTAL_OUT:  reg_rdata = word_t'(total_out);
      REG_FLAGS: begin
        reg_rdata[FLAG_BIAS_BIT] = bias_en;
        reg_rdata[FLAG_RELU_BIT] = relu_en;
      end
      default: reg_rdata = '0;
    endcase
  end

  // ========================================================================
  // Register bank
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start      <= 1'b0;
      done_flag  <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_in   <= '0;
      total_out  <= '0;
      bias_en    <= 1'b0;
      relu_en    <= 1'b0;
    end else begin
      start <= start_cmd;
      if (done)
        done_flag <= 1'b1;
      else if (start)
        done_flag <= 1'b0;
      if (accept && cmd_we && reg_hit) begin
        case (cmd_idx)
          REG_IN_OFFSET:  in_offset  <= cmd_wdata[IMGSIZE-1:0];
          REG_OUT_OFFSET: out_offset <= cmd_wdata[IMGSIZE-1:0];
          REG_NET_OFFSET: net_offset <= cmd_wdata[NETSIZE-1:0];
          REG_TOTAL_IN:   total_in   <= cmd_wdata[LWIDTH-1:0];
          REG_TOTAL_OUT:  total_out  <= cmd_wdata[LWIDTH-1:0];
          REG_FLAGS: begin
            bias_en <= cmd_wdata[FLAG_BIAS_BIT];
            relu_en <= cmd_wdata[FLAG_RELU_BIT];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== rtl/ninjin_img_buf.sv ====
module ninjin_img_buf
  import ninjin_pkg::*;
  ( input  logic      clk
  , input  logic      busy
  // Host port
  , input  logic      host_img_we
  , input  img_addr_t host_img_addr
  , input  data_t     host_img_wdata
  // Engine port
  , input  logic      eng_we
  , input  img_addr_t eng_addr
  , input  data_t     eng_wdata
  , output logic      img_ready
  , output data_t     img_rdata
  );

  data_t     mem [0:2**IMGSIZE-1];
  logic      mem_we;
  img_addr_t mem_addr;
  data_t     mem_wdata;

  // Engine owns the memory for the whole run
  assign mem_we    = busy ? eng_we    : host_img_we;
  assign mem_addr  = busy ? eng_addr  : host_img_addr;
  assign mem_wdata = busy ? eng_wdata : host_img_wdata;

  assign img_ready = !busy;

  always_ff @(posedge clk) begin
    if (mem_we)
      mem[mem_addr] <= mem_wdata;
    img_rdata <= mem[mem_addr];
  end

endmodule

// ==== rtl/ninjin_top.sv ====
module ninjin_top
  import ninjin_pkg::*;
  ( input  logic       clk
  , input  logic       xrst
  , input  logic       cmd_valid
  , input  logic       cmd_we
  , input  host_addr_t cmd_addr
  , input  word_t      cmd_wdata
  , output logic       cmd_ready
  , output logic       rsp_valid
  , output word_t      rsp_rdata
  , input  logic       rsp_ready
  );

  // ========================================================================
  // Wires
  // ========================================================================

  // Host side
  logic      host_img_we;
  img_addr_t host_img_addr;
  data_t     host_img_wdata;
  logic      net_we;
  net_addr_t net_waddr;
  data_t     net_wdata;

  // Layer parameters
  logic      start;
  img_addr_t in_offset;
  img_addr_t out_offset;
  net_addr_t net_offset;
  len_t      total_in;
  len_t      total_out;
  logic      bias_en;
  logic      relu_en;

  // Image buffer
  logic      img_ready;
  data_t     img_rdata;
  logic      eng_we;
  img_addr_t eng_addr;
  data_t     eng_wdata;

  // Engine
  logic      busy;
  logic      done;
  logic      mac_valid;
  logic      mac_first;
  logic      mac_last;
  net_addr_t w_addr;
  logic      res_valid;
  data_t     res_data;

  // ========================================================================
  // Instances
  // ========================================================================

  ninjin_host host0 (.*);

  ninjin_img_buf mem_img (.*);

  gobou_ctrl ctrl0 (.*);

  gobou_core core0 (.*);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ninjin -f verilog.f -o tb_ninjin
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_ninjin
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tb/tb_ninjin.sv ====
module tb_ninjin
  import ninjin_pkg::*;
  ();

  localparam int TCLK         = 40;
  localparam int DRV          = 5;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_IN       = 8;
  localparam int MAX_OUT      = 8;
  localparam int WAIT_LIMIT   = 64;
  localparam int POLL_LIMIT   = 200;

  // Layer A is small and hand-made, layer B is random
  localparam img_addr_t A_IN  = 12'h010;
  localparam img_addr_t A_OUT = 12'h100;
  localparam net_addr_t A_NET = 12'h020;
  localparam int        A_NIN = 4;
  localparam int        A_NOUT = 3;
  localparam img_addr_t B_IN  = 12'h200;
  localparam img_addr_t B_OUT = 12'h300;
  localparam net_addr_t B_NET = 12'h400;
  localparam int        B_NIN = 6;
  localparam int        B_NOUT = 5;

  // Three runs of layer A, one of B, plus all host traffic
  localparam int RUN_CYCLES = 3 * A_NOUT * (A_NIN + 6) + B_NOUT * (B_NIN + 6);
  localparam int HOST_OPS   = A_NOUT * (A_NIN + 1) + A_NIN + B_NOUT * (B_NIN + 1) + B_NIN
                            + 4 * (7 + MAX_OUT) + 40;
  localparam longint WATCHDOG_LIMIT =
    10 * (RESET_CYCLES + RUN_CYCLES + 4 * HOST_OPS) * TCLK;

  logic       clk;
  logic       xrst;
  logic       cmd_valid;
  logic       cmd_we;
  host_addr_t cmd_addr;
  word_t      cmd_wdata;
  logic       cmd_ready;
  logic       rsp_valid;
  word_t      rsp_rdata;
  logic       rsp_ready;

  int    seed;
  data_t x_vec [0:MAX_IN-1];
  data_t w_tab [0:MAX_OUT-1][0:MAX_IN];

  ninjin_top uut (
    .clk(clk), .xrst(xrst),
    .cmd_valid(cmd_valid), .cmd_we(cmd_we), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
    .cmd_ready(cmd_ready), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
    .rsp_ready(rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(TCLK / 2) clk = ~clk;
  end

  // ========================================================================
  // Checks
  // ========================================================================

  task automatic abort_run(string why);
    $display("Error: %s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("word value mismatch");
    end
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("data value mismatch");
    end
  endtask

  initial begin
    #(WATCHDOG_LIMIT);
    abort_run("watchdog expired before the tests finished");
  end

  // ========================================================================
  // Host port
  // ========================================================================

  function automatic host_addr_t reg_addr(logic [REGLOG-1:0] idx);
    return {REGION_REG, {(REGION_LSB-REGLOG){1'b0}}, idx};
  endfunction

  function automatic host_addr_t img_addr(img_addr_t a);
    return {REGION_IMG, {(REGION_LSB-IMGSIZE){1'b0}}, a};
  endfunction

  function automatic host_addr_t net_addr(net_addr_t a);
    return {REGION_NET, {(REGION_LSB-NETSIZE){1'b0}}, a};
  endfunction

  // One command and its response; hold keeps rsp_ready low that many cycles
  task automatic host_access(input logic we, input host_addr_t addr, input word_t wdata,
                             input int hold, output word_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #DRV;
    cmd_valid = 1'b1;
    cmd_we    = we;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    if (hold > 0)
      rsp_ready = 1'b0;
    @(negedge clk);
    while (!cmd_ready) begin
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("command was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #DRV;
    cmd_valid = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!rsp_valid) begin
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("no response for an accepted command");
      @(negedge clk);
    end
    repeat (hold) begin
      @(negedge clk);
      if (!rsp_valid)
        abort_run("response dropped while rsp_ready was low");
      if (cmd_ready)
        abort_run("host port ready for a command while a response is pending");
    end
    if (hold > 0) begin
      @(posedge clk);
      #DRV;
      rsp_ready = 1'b1;
      @(negedge clk);
    end
    rdata = rsp_rdata;
    @(posedge clk);
  endtask

  task automatic host_write(host_addr_t addr, word_t data);
    word_t rsp;
    host_access(1'b1, addr, data, 0, rsp);
    check_word("write response", rsp, '0);
  endtask

  task automatic host_read(input host_addr_t addr, output word_t data);
    host_access(1'b0, addr, '0, 0, data);
  endtask

  task automatic start_and_wait;
    word_t st;
    bit    seen_busy;
    bit    finished;
    int    polls;
    seen_busy = 1'b0;
    finished  = 1'b0;
    polls     = 0;
    host_write(reg_addr(REG_CTRL), word_t'(1) << CTRL_START_BIT);
    while (!finished) begin
      host_read(reg_addr(REG_STATUS), st);
      polls++;
      if (st[STATUS_BUSY_BIT]) begin
        seen_busy = 1'b1;
        if (st[STATUS_DONE_BIT])
          abort_run("done flag still set while the engine is busy");
      end else if (st[STATUS_DONE_BIT]) begin
        finished = 1'b1;
      end
      if (polls > POLL_LIMIT)
        abort_run("engine never reported done");
    end
    if (!seen_busy)
      abort_run("engine never reported busy after start");
  endtask

  // ========================================================================
  // Reference model and layer helpers
  // ========================================================================

  function automatic longint pre_activation(int o, int nin, bit bias_en);
    longint acc;
    int     i;
    acc = 0;
    for (i = 0; i < nin; i++)
      acc += longint'(w_tab[o][i+1]) * longint'(x_vec[i]);
    acc = acc >>> FRAC_BITS;
    if (bias_en)
      acc += longint'(w_tab[o][0]);
    return acc;
  endfunction

  function automatic data_t expected_neuron(int o, int nin, bit bias_en, bit relu_en);
    longint v;
    v = pre_activation(o, nin, bias_en);
    if (relu_en && v < 0)
      v = 0;
    if (v > longint'(DATA_MAX))
      v = longint'(DATA_MAX);
    else if (v < longint'(DATA_MIN))
      v = longint'(DATA_MIN);
    return data_t'(v);
  endfunction

  task automatic fill_layer_a;
    int o;
    int i;
    x_vec[0] = 16'sd256;
    x_vec[1] = 16'sd512;
    x_vec[2] = -16'sd256;
    x_vec[3] = 16'sd128;
    w_tab[0][0] = 16'sd100;
    w_tab[1][0] = -16'sd50;
    w_tab[2][0] = 16'sd300;
    // Neuron 1 has all negative weights and ends up below zero
    for (o = 0; o < A_NOUT; o++)
      for (i = 0; i < A_NIN; i++)
        w_tab[o][i+1] = (o == 1) ? data_t'(-96 * (i + 1)) : data_t'(40 * (i + 1) - 32 * o);
  endtask

  task automatic fill_random(int nin, int nout);
    int o;
    int j;
    for (j = 0; j < nin; j++)
      x_vec[j] = data_t'($random(seed));
    for (o = 0; o < nout; o++)
      for (j = 0; j <= nin; j++)
        w_tab[o][j] = data_t'($random(seed));
  endtask

  task automatic load_layer(img_addr_t in_off, net_addr_t net_off, int nin, int nout);
    int o;
    int j;
    for (j = 0; j < nin; j++)
      host_write(img_addr(in_off + img_addr_t'(j)), word_t'(x_vec[j]));
    for (o = 0; o < nout; o++)
      for (j = 0; j <= nin; j++)
        host_write(net_addr(net_off + net_addr_t'(o * (nin + 1) + j)), word_t'(w_tab[o][j]));
  endtask

  task automatic configure(img_addr_t in_off, img_addr_t out_off, net_addr_t net_off,
                           int nin, int nout, bit bias_en, bit relu_en);
    host_write(reg_addr(REG_IN_OFFSET), word_t'(in_off));
    host_write(reg_addr(REG_OUT_OFFSET), word_t'(out_off));
    host_write(reg_addr(REG_NET_OFFSET), word_t'(net_off));
    host_write(reg_addr(REG_TOTAL_IN), word_t'(nin));
    host_write(reg_addr(REG_TOTAL_OUT), word_t'(nout));
    host_write(reg_addr(REG_FLAGS),
               (word_t'(bias_en) << FLAG_BIAS_BIT) | (word_t'(relu_en) << FLAG_RELU_BIT));
  endtask

  task automatic check_outputs(img_addr_t out_off, int nin, int nout, bit bias_en,
                               bit relu_en);
    word_t     rd;
    img_addr_t a;
    int        o;
    for (o = 0; o < nout; o++) begin
      a = out_off + img_addr_t'(o);
      host_read(img_addr(a), rd);
      check_data($sformatf("img[%03h]", a), data_t'(rd[DWIDTH-1:0]),
                 expected_neuron(o, nin, bias_en, relu_en));
    end
  endtask

  // ========================================================================
  // Tests
  // ========================================================================

  task automatic test_registers;
    word_t rd;
    host_read(reg_addr(REG_STATUS), rd);
    check_word("STATUS after reset", rd, '0);
    host_write(reg_addr(REG_OUT_OFFSET), 32'h0000_0abc);
    host_read(reg_addr(REG_OUT_OFFSET), rd);
    check_word("OUT_OFFSET", rd, 32'h0000_0abc);
    host_write(reg_addr(REG_TOTAL_OUT), 32'h0000_0155);
    host_read(reg_addr(REG_TOTAL_OUT), rd);
    check_word("TOTAL_OUT", rd, 32'h0000_0155);
    host_write(reg_addr(REG_FLAGS), 32'h0000_0003);
    host_read(reg_addr(REG_FLAGS), rd);
    check_word("FLAGS", rd, 32'h0000_0003);
    host_read(reg_addr(4'hc), rd);
    check_word("unused register", rd, '0);
  endtask

  task automatic test_image_access;
    word_t rd;
    host_write(img_addr(12'h7f0), 32'h0000_a5c3);
    host_read(img_addr(12'h7f0), rd);
    check_data("img[7f0]", data_t'(rd[DWIDTH-1:0]), 16'ha5c3);
    host_write(img_addr(12'h7f1), 32'h0000_1e2d);
    host_access(1'b0, img_addr(12'h7f1), '0, 6, rd);
    check_data("img[7f1] held", data_t'(rd[DWIDTH-1:0]), 16'h1e2d);
    // Weight memory has no host read path
    host_write(net_addr(12'hfff), 32'h0000_7777);
    host_read(net_addr(12'hfff), rd);
    check_word("weight region read", rd, '0);
  endtask

  task automatic test_plain_layer;
    fill_layer_a();
    load_layer(A_IN, A_NET, A_NIN, A_NOUT);
    configure(A_IN, A_OUT, A_NET, A_NIN, A_NOUT, 1'b0, 1'b0);
    start_and_wait();
    check_outputs(A_OUT, A_NIN, A_NOUT, 1'b0, 1'b0);
  endtask

  task automatic test_bias_relu;
    int o;
    int negative;
    negative = 0;
    for (o = 0; o < A_NOUT; o++)
      if (pre_activation(o, A_NIN, 1'b1) < 0)
        negative++;
    if (negative == 0)
      abort_run("layer has no negative neuron for ReLU to clamp");
    host_write(reg_addr(REG_FLAGS), word_t'(3));
    start_and_wait();
    check_outputs(A_OUT, A_NIN, A_NOUT, 1'b1, 1'b1);
  endtask

  task automatic test_saturation;
    word_t rd;
    data_t e;
    int    o;
    int    i;
    int    saturated;
    saturated = 0;
    fill_random(B_NIN, B_NOUT);
    for (o = 0; o < B_NOUT; o++) begin
      e = expected_neuron(o, B_NIN, 1'b1, 1'b0);
      if (e == DATA_MAX || e == DATA_MIN)
        saturated++;
    end
    if (saturated == 0)
      abort_run("random layer produced no saturated output");
    load_layer(B_IN, B_NET, B_NIN, B_NOUT);
    configure(B_IN, B_OUT, B_NET, B_NIN, B_NOUT, 1'b1, 1'b0);
    start_and_wait();
    check_outputs(B_OUT, B_NIN, B_NOUT, 1'b1, 1'b0);
    for (i = 0; i < B_NIN; i++) begin
      host_read(img_addr(B_IN + img_addr_t'(i)), rd);
      check_data("input after run", data_t'(rd[DWIDTH-1:0]), x_vec[i]);
    end
  endtask

  task automatic test_status_rerun;
    word_t rd;
    host_read(reg_addr(REG_STATUS), rd);
    check_word("STATUS after run", rd, word_t'(1) << STATUS_DONE_BIT);
    // Layer A weights and inputs are still in place
    fill_layer_a();
    configure(A_IN, A_OUT, A_NET, A_NIN, A_NOUT, 1'b1, 1'b0);
    start_and_wait();
    check_outputs(A_OUT, A_NIN, A_NOUT, 1'b1, 1'b0);
    host_read(reg_addr(REG_STATUS), rd);
    check_word("STATUS after second run", rd, word_t'(1) << STATUS_DONE_BIT);
  endtask

  initial begin
    xrst      = 1'b0;
    cmd_valid = 1'b0;
    cmd_we    = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    rsp_ready = 1'b1;
    seed      = 31687;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRV;
    xrst = 1'b1;
    test_registers();
    test_image_access();
    test_plain_layer();
    test_bias_relu();
    test_saturation();
    test_status_rerun();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/ninjin_pkg.sv
rtl/ninjin_img_buf.sv
rtl/ninjin_host.sv
gobou/gobou_ctrl.sv
gobou/gobou_core.sv
rtl/ninjin_top.sv
tb/tb_ninjin.sv
